// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pooling stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module tb_pool_stage \
    -o sim_pool_stage

./obj_dir/sim_pool_stage

// ==== src/credit_fifo.sv ====
module credit_fifo #(
    parameter type PAYLOAD_T = logic [15:0],
    parameter int  DEPTH     = pool_pkg::DEF_IN_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_push,
    input  PAYLOAD_T                   i_data,
    input  logic                       i_pop,
    output PAYLOAD_T                   o_data,
    output logic                       o_empty,
    output logic [pool_pkg::CNT_W-1:0] o_count
);

    // pointer width, at least one bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // storage
    PAYLOAD_T mem [DEPTH];

    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [pool_pkg::CNT_W-1:0] count_q;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // data path
    ////////////////////////////////////////

    // write slot at tail
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

    // show-ahead, head is always on the output
    assign o_data = mem[rd_ptr_q];

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (i_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // push and pop together leave the count alone
            case ({i_push, i_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign o_empty = (count_q == '0);
    assign o_count = count_q;

endmodule

// ==== src/line_window.sv ====
module line_window #(
    parameter int PIX_W = pool_pkg::DEF_PIX_W,
    parameter int IMG_W = pool_pkg::DEF_IMG_W
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_shift,
    input  logic [$clog2(IMG_W)-1:0]   i_col,
    input  logic signed [PIX_W-1:0]    i_pixel,
    output logic signed [PIX_W-1:0]    o_w00,
    output logic signed [PIX_W-1:0]    o_w01,
    output logic signed [PIX_W-1:0]    o_w10,
    output logic signed [PIX_W-1:0]    o_w11
);

    ////////////////////////////////////////
    // row memory
    ////////////////////////////////////////

    // one slot per column
    // slot c holds the previous row until the current row reaches c
    logic signed [PIX_W-1:0] row_mem [IMG_W];

    // pixel one column to the left, current row
    logic signed [PIX_W-1:0] left_q;

    // pixel one column to the left, previous row
    // slot i_col-1 is already overwritten by the current row,
    // so the old value is kept here on its way out
    logic signed [PIX_W-1:0] up_left_q;

    // previous-row pixel above the current column
    logic signed [PIX_W-1:0] up_cur;

    assign up_cur = row_mem[i_col];

    // each shifted pixel replaces its column slot
    always_ff @(posedge clk) begin
        if (i_shift) begin
            row_mem[i_col] <= i_pixel;
        end
    end

    ////////////////////////////////////////
    // left-hand registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            left_q    <= '0;
            up_left_q <= '0;
        end else if (i_shift) begin
            // current pixel becomes the left neighbour of the next one
            left_q    <= i_pixel;
            // slot content before it is overwritten
            up_left_q <= up_cur;
        end
    end

    ////////////////////////////////////////
    // window outputs
    ////////////////////////////////////////

    // top row, previous image row
    assign o_w00 = up_left_q;
    assign o_w01 = up_cur;

    // bottom row, current image row
    // combinational from the popped pixel
    assign o_w10 = left_q;
    assign o_w11 = i_pixel;

    // at column 0 the left registers hold the end of the row above,
    // never read since windows only close on odd columns

endmodule

// ==== src/max_pool_unit.sv ====
module max_pool_unit #(
    parameter int CHANNELS = pool_pkg::DEF_CHANNELS,
    parameter int PIX_W    = pool_pkg::DEF_PIX_W
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        i_valid,
    input  logic [CHANNELS*pool_pkg::WIN_PIX*PIX_W-1:0] i_windows,
    output logic                                        o_valid,
    output logic [CHANNELS*PIX_W-1:0]                   o_pool,
    output logic [pool_pkg::CNT_W-1:0]                  o_inflight
);

    localparam int LAT = pool_pkg::POOL_LATENCY;
    localparam int WIN = pool_pkg::WIN_PIX;

    // valid per stage, bit 0 is stage 1
    logic [LAT-1:0] vld_q;

    // signed maximum of two pixels
    function automatic logic signed [PIX_W-1:0] smax(
        input logic signed [PIX_W-1:0] a,
        input logic signed [PIX_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    ////////////////////////////////////////
    // valid pipe, control only
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAT-2:0], i_valid};
        end
    end

    assign o_valid = vld_q[LAT-1];

    // occupied stages
    always_comb begin
        o_inflight = '0;
        for (int s = 0; s < LAT; s++) begin
            o_inflight = o_inflight + pool_pkg::CNT_W'(vld_q[s]);
        end
    end

    ////////////////////////////////////////
    // per-channel compare tree
    ////////////////////////////////////////

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_ch
        logic signed [PIX_W-1:0] w00;
        logic signed [PIX_W-1:0] w01;
        logic signed [PIX_W-1:0] w10;
        logic signed [PIX_W-1:0] w11;
        logic signed [PIX_W-1:0] top_q;
        logic signed [PIX_W-1:0] bot_q;
        logic signed [PIX_W-1:0] res_q;

        // window order inside a channel: w00 w01 w10 w11
        assign w00 = i_windows[(ch*WIN + 0)*PIX_W +: PIX_W];
        assign w01 = i_windows[(ch*WIN + 1)*PIX_W +: PIX_W];
        assign w10 = i_windows[(ch*WIN + 2)*PIX_W +: PIX_W];
        assign w11 = i_windows[(ch*WIN + 3)*PIX_W +: PIX_W];

        // stage 1, row pairs
        always_ff @(posedge clk) begin
            if (i_valid) begin
                top_q <= smax(w00, w01);
                bot_q <= smax(w10, w11);
            end
        end

        // stage 2, final max
        always_ff @(posedge clk) begin
            if (vld_q[0]) begin
                res_q <= smax(top_q, bot_q);
            end
        end

        assign o_pool[ch*PIX_W +: PIX_W] = res_q;
    end

endmodule

// ==== src/pool_pkg.sv ====
package pool_pkg;

    ////////////////////////////////////////
    // pooling geometry
    ////////////////////////////////////////

    // window side, stride equals window side
    localparam int POOL_K = 2;

    // pixels held by one window
    localparam int WIN_PIX = POOL_K * POOL_K;

    // pop of completing pixel to push into output fifo
    localparam int POOL_LATENCY = 2;

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    // credit and occupancy counter width
    localparam int CNT_W = 8;

    ////////////////////////////////////////
    // top-level defaults
    ////////////////////////////////////////

    localparam int DEF_CHANNELS    = 3;
    localparam int DEF_PIX_W       = 16;
    // image width, must be even
    localparam int DEF_IMG_W       = 8;
    localparam int DEF_IN_DEPTH    = 4;
    localparam int DEF_OUT_DEPTH   = 4;
    // credits the downstream grants after reset
    localparam int DEF_OUT_CREDITS = 4;

endpackage

// ==== src/pool_stage_top.sv ====
module pool_stage_top #(
    parameter int CHANNELS    = pool_pkg::DEF_CHANNELS,
    parameter int PIX_W       = pool_pkg::DEF_PIX_W,
    parameter int IMG_W       = pool_pkg::DEF_IMG_W,
    parameter int IN_DEPTH    = pool_pkg::DEF_IN_DEPTH,
    parameter int OUT_DEPTH   = pool_pkg::DEF_OUT_DEPTH,
    parameter int OUT_CREDITS = pool_pkg::DEF_OUT_CREDITS
) (
    input  logic                      clk,
    input  logic                      reset_n,
    // upstream, credit based
    input  logic                      i_in_valid,
    input  logic [CHANNELS*PIX_W-1:0] i_in_pixels,
    output logic                      o_in_credit,
    // downstream, credit based
    output logic                      o_out_valid,
    output logic [CHANNELS*PIX_W-1:0] o_out_pool,
    input  logic                      i_out_credit
);

    localparam int CNT_W = pool_pkg::CNT_W;
    localparam int WIN   = pool_pkg::WIN_PIX;
    localparam int COL_W = $clog2(IMG_W);

    typedef logic [CHANNELS*PIX_W-1:0] pix_vec_t;
    typedef logic [CHANNELS*PIX_W-1:0] res_vec_t;

    pix_vec_t                     in_head;
    logic                         in_empty;
    logic [CNT_W-1:0]             in_count;
    logic                         in_pop;
    logic                         in_credit_q;
    logic [COL_W-1:0]             col;
    logic                         win_done;
    logic [CHANNELS*WIN*PIX_W-1:0] windows;
    logic                         mp_valid;
    res_vec_t                     mp_pool;
    logic [CNT_W-1:0]             inflight;
    logic                         out_empty;
    logic [CNT_W-1:0]             out_count;
    logic [CNT_W:0]               reserved;
    logic [CNT_W-1:0]             out_cred_q;
    logic                         send;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    // upstream only sends with a credit, so no overflow here
    credit_fifo #(
        .PAYLOAD_T (pix_vec_t),
        .DEPTH     (IN_DEPTH)
    ) u_in_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .i_push  (i_in_valid),
        .i_data  (i_in_pixels),
        .i_pop   (in_pop),
        .o_data  (in_head),
        .o_empty (in_empty),
        .o_count (in_count)
    );

    // admission, keep a slot for everything already in the pipe
    assign reserved = {1'b0, out_count} + {1'b0, inflight};
    assign in_pop   = !in_empty && (reserved < (CNT_W + 1)'(OUT_DEPTH));

    // one credit back per pop, registered
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_credit_q <= 1'b0;
        end else begin
            in_credit_q <= in_pop;
        end
    end

    assign o_in_credit = in_credit_q;

    ////////////////////////////////////////
    // window formation and max
    ////////////////////////////////////////

    raster_tracker #(
        .IMG_W (IMG_W)
    ) u_tracker (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_step        (in_pop),
        .o_col         (col),
        .o_window_done (win_done)
    );

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_lw
        line_window #(
            .PIX_W (PIX_W),
            .IMG_W (IMG_W)
        ) u_lw (
            .clk     (clk),
            .reset_n (reset_n),
            .i_shift (in_pop),
            .i_col   (col),
            .i_pixel (in_head[ch*PIX_W +: PIX_W]),
            .o_w00   (windows[(ch*WIN + 0)*PIX_W +: PIX_W]),
            .o_w01   (windows[(ch*WIN + 1)*PIX_W +: PIX_W]),
            .o_w10   (windows[(ch*WIN + 2)*PIX_W +: PIX_W]),
            .o_w11   (windows[(ch*WIN + 3)*PIX_W +: PIX_W])
        );
    end

    max_pool_unit #(
        .CHANNELS (CHANNELS),
        .PIX_W    (PIX_W)
    ) u_max (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_valid    (win_done),
        .i_windows  (windows),
        .o_valid    (mp_valid),
        .o_pool     (mp_pool),
        .o_inflight (inflight)
    );

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    credit_fifo #(
        .PAYLOAD_T (res_vec_t),
        .DEPTH     (OUT_DEPTH)
    ) u_out_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .i_push  (mp_valid),
        .i_data  (mp_pool),
        .i_pop   (send),
        .o_data  (o_out_pool),
        .o_empty (out_empty),
        .o_count (out_count)
    );

    // downstream takes every beat it is offered
    assign send        = (out_cred_q != '0) && !out_empty;
    assign o_out_valid = send;

    // credits held, send and return may coincide
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_cred_q <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({send, i_out_credit})
                2'b10:   out_cred_q <= out_cred_q - 1'b1;
                2'b01:   out_cred_q <= out_cred_q + 1'b1;
                default: out_cred_q <= out_cred_q;
            endcase
        end
    end

endmodule

// ==== src/raster_tracker.sv ====
module raster_tracker #(
    parameter int IMG_W = pool_pkg::DEF_IMG_W
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_step,
    output logic [$clog2(IMG_W)-1:0] o_col,
    output logic                     o_window_done
);

    localparam int COL_W = $clog2(IMG_W);

    // column of the pixel being stepped
    logic [COL_W-1:0] col_q;

    // high on odd rows
    logic row_odd_q;

    // last column of the row
    logic col_last;

    // last column of a window, odd for K of 2
    logic col_win_end;

    assign col_last    = (col_q == COL_W'(IMG_W - 1));
    assign col_win_end = ((col_q % pool_pkg::POOL_K) == (pool_pkg::POOL_K - 1));

    ////////////////////////////////////////
    // raster position
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_q     <= '0;
            row_odd_q <= 1'b0;
        end else if (i_step) begin
            if (col_last) begin
                // wrap to next row, flip parity
                col_q     <= '0;
                row_odd_q <= ~row_odd_q;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // bottom-right pixel of a window arriving now
    assign o_window_done = i_step && row_odd_q && col_win_end;

    assign o_col = col_q;

endmodule

// ==== tb.f ====
src/pool_pkg.sv
src/credit_fifo.sv
src/line_window.sv
src/raster_tracker.sv
src/max_pool_unit.sv
src/pool_stage_top.sv
verif/clk_gen.sv
verif/pool_stage_checker.sv
verif/tb_pool_stage.sv

// ==== verif/clk_gen.sv ====
module clk_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic o_clk
);

    // starts low, first rising edge after one half period
    initial begin
        o_clk = 1'b0;
    end

    always #HALF_PERIOD o_clk = ~o_clk;

endmodule

// ==== verif/pool_stage_checker.sv ====
module pool_stage_checker #(
    parameter int IN_DEPTH    = pool_pkg::DEF_IN_DEPTH,
    parameter int OUT_DEPTH   = pool_pkg::DEF_OUT_DEPTH,
    parameter int OUT_CREDITS = pool_pkg::DEF_OUT_CREDITS
) (
    input logic                       clk,
    input logic                       reset_n,
    input logic                       i_in_push,
    input logic                       i_in_pop,
    input logic [pool_pkg::CNT_W-1:0] i_in_count,
    input logic                       i_out_push,
    input logic                       i_out_pop,
    input logic [pool_pkg::CNT_W-1:0] i_out_count,
    input logic [pool_pkg::CNT_W-1:0] i_out_cred,
    input logic                       i_out_ret,
    input logic                       i_out_valid,
    input logic                       i_in_credit
);

    localparam int CNT_W = pool_pkg::CNT_W;

    // occupancy and credits rebuilt from the strobes alone
    logic [CNT_W-1:0] in_occ_q;
    logic [CNT_W-1:0] out_occ_q;
    logic [CNT_W-1:0] cred_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_occ_q  <= '0;
            out_occ_q <= '0;
            cred_q    <= CNT_W'(OUT_CREDITS);
        end else begin
            in_occ_q  <= in_occ_q + CNT_W'(i_in_push) - CNT_W'(i_in_pop);
            out_occ_q <= out_occ_q + CNT_W'(i_out_push) - CNT_W'(i_out_pop);
            // one back per returned credit, one spent per beat
            cred_q    <= cred_q + CNT_W'(i_out_ret) - CNT_W'(i_out_valid);
        end
    end

    ////////////////////////////////////////
    // fifo bounds
    ////////////////////////////////////////

    // push into a full input fifo
    a_in_overflow : assert property (@(posedge clk) disable iff (!reset_n)
        (i_in_push && !i_in_pop) |-> (in_occ_q < CNT_W'(IN_DEPTH)))
        else $error("input fifo overflow");

    // pop from an empty input fifo
    a_in_underflow : assert property (@(posedge clk) disable iff (!reset_n)
        i_in_pop |-> (in_occ_q != '0))
        else $error("input fifo underflow");

    a_in_count : assert property (@(posedge clk) disable iff (!reset_n)
        i_in_count == in_occ_q)
        else $error("input fifo count does not follow its pushes and pops");

    a_out_overflow : assert property (@(posedge clk) disable iff (!reset_n)
        (i_out_push && !i_out_pop) |-> (out_occ_q < CNT_W'(OUT_DEPTH)))
        else $error("output fifo overflow");

    a_out_underflow : assert property (@(posedge clk) disable iff (!reset_n)
        i_out_pop |-> (out_occ_q != '0))
        else $error("output fifo underflow");

    a_out_count : assert property (@(posedge clk) disable iff (!reset_n)
        i_out_count == out_occ_q)
        else $error("output fifo count does not follow its pushes and pops");

    ////////////////////////////////////////
    // credits and reset
    ////////////////////////////////////////

    // a beat is only offered against a held credit
    a_out_credit : assert property (@(posedge clk) disable iff (!reset_n)
        i_out_valid |-> (cred_q != '0))
        else $error("output beat sent with zero credits");

    a_cred_count : assert property (@(posedge clk) disable iff (!reset_n)
        i_out_cred == cred_q)
        else $error("output credit counter does not follow sends and returns");

    // both strobes quiet while reset is held
    a_reset_quiet : assert property (@(posedge clk)
        !reset_n |-> (!i_out_valid && !i_in_credit))
        else $error("valid or credit strobe high during reset");

endmodule

// attach to every pool_stage_top, internal nets by name
bind pool_stage_top pool_stage_checker #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) u_checker (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_in_push   (i_in_valid),
    .i_in_pop    (in_pop),
    .i_in_count  (in_count),
    .i_out_push  (mp_valid),
    .i_out_pop   (send),
    .i_out_count (out_count),
    .i_out_cred  (out_cred_q),
    .i_out_ret   (i_out_credit),
    .i_out_valid (o_out_valid),
    .i_in_credit (o_in_credit)
);

// ==== verif/tb_pool_stage.sv ====
module tb_pool_stage;

    localparam int CH        = pool_pkg::DEF_CHANNELS;
    localparam int PW        = pool_pkg::DEF_PIX_W;
    localparam int IMG_W     = pool_pkg::DEF_IMG_W;
    localparam int IN_DEPTH  = pool_pkg::DEF_IN_DEPTH;
    localparam int OUT_CRED  = pool_pkg::DEF_OUT_CREDITS;
    localparam int CNT_W     = pool_pkg::CNT_W;
    // rows of random traffic, then rows with credits withheld
    localparam int ROWS_A    = 12;
    localparam int ROWS_B    = 8;
    localparam int WAIT_MAX  = 5000;
    localparam int STALL_CYC = 40;
    // downstream credit return modes
    localparam int CRED_HOLD   = 0;
    localparam int CRED_RANDOM = 1;
    localparam int CRED_ALL    = 2;

    typedef logic [CH*PW-1:0] pix_vec_t;
    typedef logic [CH*PW-1:0] res_vec_t;
    typedef logic [CNT_W-1:0] cnt_t;

    logic     clk;
    logic     reset_n;
    logic     i_in_valid;
    pix_vec_t i_in_pixels;
    logic     o_in_credit;
    logic     o_out_valid;
    res_vec_t o_out_pool;
    logic     i_out_credit;

    integer seed;

    // upstream and downstream bookkeeping
    int   in_credits;
    int   in_pulses;
    int   px_sent;
    int   px_target;
    int   beats_rx;
    int   credits_ret;
    int   cyc;
    int   last_credit_cyc;
    logic send_en;
    int   credit_mode;

    // reference model state
    res_vec_t             exp_q [$];
    logic signed [PW-1:0] prev_row [CH][IMG_W];
    logic signed [PW-1:0] cur_row  [CH][IMG_W];

    clk_gen #(.HALF_PERIOD(2)) u_clk (.o_clk(clk));

    pool_stage_top dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_pixels  (i_in_pixels),
        .o_in_credit  (o_in_credit),
        .o_out_valid  (o_out_valid),
        .o_out_pool   (o_out_pool),
        .i_out_credit (i_out_credit)
    );

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_pool(input string name, input res_vec_t got, input res_vec_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("pooled value differs from the reference window maximum");
        end
    endtask

    task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("count differs from the expected value");
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // signed max over one 2x2 window
    function automatic logic signed [PW-1:0] window_max(
        input logic signed [PW-1:0] a,
        input logic signed [PW-1:0] b,
        input logic signed [PW-1:0] c,
        input logic signed [PW-1:0] d
    );
        logic signed [PW-1:0] m;
        m = a;
        if (b > m) m = b;
        if (c > m) m = c;
        if (d > m) m = d;
        return m;
    endfunction

    // raster position from the pixel index, window closes on odd row and odd col
    task automatic model_pixel(input pix_vec_t pix);
        int       col;
        int       row;
        res_vec_t exp;
        col = px_sent % IMG_W;
        row = px_sent / IMG_W;
        exp = '0;
        for (int ch = 0; ch < CH; ch++) begin
            cur_row[ch][col] = pix[ch*PW +: PW];
        end
        if ((row % 2 == 1) && (col % 2 == 1)) begin
            for (int ch = 0; ch < CH; ch++) begin
                exp[ch*PW +: PW] = window_max(prev_row[ch][col-1], prev_row[ch][col],
                                              cur_row[ch][col-1], cur_row[ch][col]);
            end
            exp_q.push_back(exp);
        end
        // row finished, it becomes the row above
        if (col == IMG_W - 1) begin
            prev_row = cur_row;
        end
    endtask

    ////////////////////////////////////////
    // per-cycle bus activity
    ////////////////////////////////////////

    task automatic sample_outputs();
        res_vec_t exp;
        if (o_in_credit === 1'b1) begin
            in_pulses++;
            in_credits++;
            last_credit_cyc = cyc;
            if (in_credits > IN_DEPTH) begin
                abort_run("upstream credit count rose above the initial grant");
            end
        end
        if (o_out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("output beat arrived with no window expected");
            end else begin
                exp = exp_q.pop_front();
                check_pool("o_out_pool", o_out_pool, exp);
                beats_rx++;
                if (beats_rx - credits_ret > OUT_CRED) begin
                    abort_run("more output beats outstanding than credits granted");
                end
            end
        end
    endtask

    // send only while a credit is held
    task automatic drive_upstream();
        pix_vec_t pix;
        if (reset_n && send_en && (px_sent < px_target) && (in_credits > 0) &&
            (($random(seed) & 3) != 0)) begin
            // full range, negatives included
            for (int ch = 0; ch < CH; ch++) begin
                pix[ch*PW +: PW] = PW'($random(seed));
            end
            i_in_valid  <= 1'b1;
            i_in_pixels <= pix;
            in_credits--;
            model_pixel(pix);
            px_sent++;
        end else begin
            i_in_valid <= 1'b0;
        end
    endtask

    // never return more than is owed
    task automatic drive_credit_return();
        logic give;
        give = 1'b0;
        if (reset_n && (beats_rx > credits_ret)) begin
            if (credit_mode == CRED_ALL) begin
                give = 1'b1;
            end else if (credit_mode == CRED_RANDOM) begin
                give = (($random(seed) & 1) != 0);
            end
        end
        i_out_credit <= give;
        if (give) begin
            credits_ret++;
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        sample_outputs();
        drive_upstream();
        drive_credit_return();
    end

    ////////////////////////////////////////
    // waits, sampled on the falling edge
    ////////////////////////////////////////

    // last credit pulse comes back before the last result
    task automatic wait_drained(input string what);
        int t;
        t = 0;
        while (!((px_sent == px_target) && (exp_q.size() == 0) &&
                 (credits_ret == beats_rx))) begin
            @(negedge clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run({"timeout waiting for ", what, " to drain"});
            end
        end
    endtask

    // upstream out of credits and no pop for a long stretch
    task automatic wait_stall();
        int t;
        t = 0;
        while (!((in_credits == 0) && (cyc - last_credit_cyc > STALL_CYC))) begin
            @(negedge clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run("timeout waiting for input credits to stop while output is held");
            end
        end
    endtask

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////

    initial begin
        int beats_before;
        seed            = 80557;
        reset_n         = 1'b0;
        i_in_valid      = 1'b0;
        i_in_pixels     = '0;
        i_out_credit    = 1'b0;
        in_credits      = IN_DEPTH;
        in_pulses       = 0;
        px_sent         = 0;
        px_target       = 0;
        beats_rx        = 0;
        credits_ret     = 0;
        cyc             = 0;
        last_credit_cyc = 0;
        send_en         = 1'b0;
        credit_mode     = CRED_HOLD;

        // strobes stay low in reset and just after
        repeat (2) begin
            @(negedge clk);
            check_count("o_out_valid", cnt_t'(o_out_valid), '0);
            check_count("o_in_credit", cnt_t'(o_in_credit), '0);
        end
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_count("o_out_valid", cnt_t'(o_out_valid), '0);
            check_count("o_in_credit", cnt_t'(o_in_credit), '0);
        end

        // random traffic both sides
        px_target   = ROWS_A * IMG_W;
        credit_mode = CRED_RANDOM;
        send_en     = 1'b1;
        wait_drained("random traffic");
        check_count("output beats", cnt_t'(beats_rx), cnt_t'((ROWS_A / 2) * (IMG_W / 2)));
        check_count("o_in_credit pulses", cnt_t'(in_pulses), cnt_t'(px_sent));
        check_count("upstream credits", cnt_t'(in_credits), cnt_t'(IN_DEPTH));

        // downstream holds its credits, pipe must back up to the upstream
        credit_mode = CRED_HOLD;
        px_target   = (ROWS_A + ROWS_B) * IMG_W;
        wait_stall();
        if (px_sent >= px_target) begin
            abort_run("all pixels were taken although the output was held");
        end
        check_count("outstanding output beats", cnt_t'(beats_rx - credits_ret), cnt_t'(OUT_CRED));
        beats_before = beats_rx;
        repeat (STALL_CYC) @(negedge clk);
        check_count("output beats while held", cnt_t'(beats_rx), cnt_t'(beats_before));

        // release, everything queued must come out
        credit_mode = CRED_ALL;
        wait_drained("held results");
        check_count("output beats", cnt_t'(beats_rx),
                    cnt_t'(((ROWS_A + ROWS_B) / 2) * (IMG_W / 2)));
        check_count("o_in_credit pulses", cnt_t'(in_pulses), cnt_t'(px_sent));
        check_count("upstream credits", cnt_t'(in_credits), cnt_t'(IN_DEPTH));

        $display("STATUS: PASS");
        $finish;
    end

endmodule
